// File: rtl/dcore_config.svh
`ifndef DCORE_CONFIG_SVH
`define DCORE_CONFIG_SVH

// time-interleaved ADC slices per clk_adc cycle
`define NTI 4

// code width, sign plus NADC-1 magnitude bits
`define NADC 8

// PRBS order for the checker
`define NPRBS 7

// snapshot memory geometry
`define CAP_DEPTH 16
`define CAP_AW 4

`endif

// File: rtl/dcore_pkg.sv
`default_nettype none
`include "dcore_config.svh"

package dcore_pkg;

    // slice magnitude and signed code
    typedef logic [`NADC-2:0] adc_mag_t;
    typedef logic signed [`NADC-1:0] adc_code_t;

    // room for 128 codes in one averaging window
    typedef logic signed [`NADC+6:0] adc_sum_t;

    typedef logic [31:0] bit_cnt_t;

    typedef enum logic [1:0] {CHK_CLEAR, CHK_ALIGN, CHK_RUN, CHK_FREEZE} chk_mode_e;

    typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_WRITE, CAP_DONE} cap_state_e;

    // APB byte addresses
    typedef enum logic [7:0] {
        REG_CTRL     = 8'h00,
        REG_EXT_OFS  = 8'h04,
        REG_CAL_OFS  = 8'h08,
        REG_PRBS_TOT = 8'h0C,
        REG_PRBS_ERR = 8'h10,
        REG_CAP_CTRL = 8'h14,
        REG_CAP_ADDR = 8'h18,
        REG_CAP_DATA = 8'h1C
    } reg_addr_e;

endpackage

`default_nettype wire

// File: rtl/dcore_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

interface dcore_cfg_if import dcore_pkg::*; ();

    // configuration from the register block
    logic                  cal_en;
    logic                  ext_ofs_en;
    logic [2:0]            navg;
    adc_code_t             ext_ofs [`NTI-1:0];
    chk_mode_e             chk_mode;
    logic                  cap_arm;
    logic [`CAP_AW-1:0]    cap_addr;

    // status from the datapath
    adc_code_t             cal_ofs [`NTI-1:0];
    bit_cnt_t              prbs_total;
    bit_cnt_t              prbs_err;
    cap_state_e            cap_state;
    adc_code_t             cap_data [`NTI-1:0];

    modport regs (
        output cal_en, ext_ofs_en, navg, ext_ofs, chk_mode, cap_arm, cap_addr,
        input  cal_ofs, prbs_total, prbs_err, cap_state, cap_data
    );

    modport core (
        input  cal_en, ext_ofs_en, navg, ext_ofs, chk_mode, cap_arm, cap_addr,
        output cal_ofs, prbs_total, prbs_err, cap_state, cap_data
    );

endinterface

`default_nettype wire

// File: rtl/dcore_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module dcore_regs import dcore_pkg::*; (
    input  wire logic        clk_adc,
    input  wire logic        rst_i,
    input  wire logic [7:0]  paddr_i,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [31:0] pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    dcore_cfg_if.regs        cfg
);
    logic        access;
    logic        mapped;
    logic        read_only;
    logic        wr_ok;
    logic [31:0] rd_mux;

    assign access   = psel_i && penable_i;
    assign pready_o = 1'b1;

    // decode and read mux
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        rd_mux    = '0;
        case (reg_addr_e'(paddr_i))
            REG_CTRL: rd_mux[6:0] = {cfg.chk_mode, cfg.navg, cfg.ext_ofs_en, cfg.cal_en};
            REG_EXT_OFS: begin
                for (int i = 0; i < `NTI; i++) rd_mux[i*`NADC +: `NADC] = cfg.ext_ofs[i];
            end
            REG_CAL_OFS: begin
                read_only = 1'b1;
                for (int i = 0; i < `NTI; i++) rd_mux[i*`NADC +: `NADC] = cfg.cal_ofs[i];
            end
            REG_PRBS_TOT: begin
                read_only = 1'b1;
                rd_mux    = cfg.prbs_total;
            end
            REG_PRBS_ERR: begin
                read_only = 1'b1;
                rd_mux    = cfg.prbs_err;
            end
            REG_CAP_CTRL: rd_mux[1:0] = cfg.cap_state;
            REG_CAP_ADDR: rd_mux[`CAP_AW-1:0] = cfg.cap_addr;
            REG_CAP_DATA: begin
                read_only = 1'b1;
                for (int i = 0; i < `NTI; i++) rd_mux[i*`NADC +: `NADC] = cfg.cap_data[i];
            end
            default: mapped = 1'b0;
        endcase
    end

    // zero wait states, so data and error are driven in the access phase
    assign prdata_o  = (access && !pwrite_i) ? rd_mux : '0;
    assign pslverr_o = access && (!mapped || (pwrite_i && read_only));
    assign wr_ok     = access && pwrite_i && mapped && !read_only;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            cfg.cal_en     <= 1'b0;
            cfg.ext_ofs_en <= 1'b0;
            cfg.navg       <= '0;
            cfg.chk_mode   <= CHK_CLEAR;
            cfg.cap_arm    <= 1'b0;
            cfg.cap_addr   <= '0;
            for (int i = 0; i < `NTI; i++) cfg.ext_ofs[i] <= '0;
        end else begin
            // arm is a single-cycle strobe
            cfg.cap_arm <= 1'b0;
            if (wr_ok) begin
                case (reg_addr_e'(paddr_i))
                    REG_CTRL: begin
                        cfg.cal_en     <= pwdata_i[0];
                        cfg.ext_ofs_en <= pwdata_i[1];
                        cfg.navg       <= pwdata_i[4:2];
                        cfg.chk_mode   <= chk_mode_e'(pwdata_i[6:5]);
                    end
                    REG_EXT_OFS: begin
                        for (int i = 0; i < `NTI; i++) begin
                            cfg.ext_ofs[i] <= adc_code_t'(pwdata_i[i*`NADC +: `NADC]);
                        end
                    end
                    REG_CAP_CTRL: cfg.cap_arm <= pwdata_i[0];
                    REG_CAP_ADDR: cfg.cap_addr <= pwdata_i[`CAP_AW-1:0];
                    default: ;
                endcase
            end
        end
    end

    // setup phase always moves on to the access phase
    a_apb_setup_access: assert property (@(posedge clk_adc) disable iff (rst_i)
        psel_i && !penable_i |=> psel_i && penable_i);

endmodule

`default_nettype wire

// File: rtl/avg_timer.sv
`timescale 1ns/1ps
`default_nettype none

module avg_timer (
    input  wire logic       clk_adc,
    input  wire logic       rst_i,
    input  wire logic [2:0] navg_i,
    output logic            win_end_o
);
    logic [6:0] cnt;
    logic [6:0] term;
    logic [2:0] navg_q;

    // window of 2^navg cycles
    assign term      = (7'd1 << navg_i) - 7'd1;
    assign win_end_o = (cnt == term) && (navg_i == navg_q);

    always_ff @(posedge clk_adc) begin
        navg_q <= navg_i;
        // restart the window on a new navg setting
        if (rst_i || navg_i != navg_q || win_end_o) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 7'd1;
        end
    end

    a_strobe_single: assert property (@(posedge clk_adc) disable iff (rst_i)
        win_end_o && navg_i != 3'd0 |=> !win_end_o);

endmodule

`default_nettype wire

// File: rtl/adc_unfold.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module adc_unfold import dcore_pkg::*; (
    input  wire logic       clk_adc,
    input  wire logic       rst_i,
    input  wire adc_mag_t   mag_i,
    input  wire logic       sign_i,
    input  wire logic       win_end_i,
    input  wire logic       cal_en_i,
    input  wire logic       ext_ofs_en_i,
    input  wire adc_code_t  ext_ofs_i,
    input  wire logic [2:0] navg_i,
    output adc_code_t       code_o,
    output adc_code_t       cal_ofs_o
);
    adc_code_t              raw_code;
    adc_code_t              act_ofs;
    logic signed [`NADC:0]  diff;
    adc_sum_t               win_sum;
    adc_sum_t               sum_next;

    // sign high is a positive sample
    assign raw_code = sign_i ? adc_code_t'({1'b0, mag_i}) : -adc_code_t'({1'b0, mag_i});
    assign act_ofs  = ext_ofs_en_i ? ext_ofs_i : cal_ofs_o;

    // one extra bit so the subtraction cannot wrap
    assign diff = {raw_code[`NADC-1], raw_code} - {act_ofs[`NADC-1], act_ofs};

    always_ff @(posedge clk_adc) begin
        if (diff[`NADC] != diff[`NADC-1]) begin
            // clip to the code range
            code_o <= diff[`NADC] ? adc_code_t'({1'b1, {(`NADC-1){1'b0}}})
                                  : adc_code_t'({1'b0, {(`NADC-1){1'b1}}});
        end else begin
            code_o <= adc_code_t'(diff[`NADC-1:0]);
        end
    end

    assign sum_next = win_sum + adc_sum_t'(raw_code);

    // window average, current sample included
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            win_sum   <= '0;
            cal_ofs_o <= '0;
        end else if (win_end_i) begin
            win_sum <= '0;
            if (cal_en_i) begin
                cal_ofs_o <= adc_code_t'(sum_next >>> navg_i);
            end
        end else begin
            win_sum <= sum_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module prbs_checker import dcore_pkg::*; (
    input  wire logic      clk_adc,
    input  wire logic      rst_i,
    input  wire adc_code_t code_i [`NTI-1:0],
    input  wire chk_mode_e mode_i,
    output bit_cnt_t       total_o,
    output bit_cnt_t       err_o
);
    logic [`NTI-1:0]             rx_bits;
    logic [`NPRBS-1:0]           lfsr_q;
    logic [`NPRBS-1:0]           lfsr_d;
    logic [$clog2(`NTI+1)-1:0]   n_err;
    logic                        exp_bit;

    // non-negative code decides a one
    always_comb begin
        for (int i = 0; i < `NTI; i++) rx_bits[i] = !code_i[i][`NADC-1];
    end

    // slice 0 is the oldest bit of the cycle
    always_comb begin
        lfsr_d  = lfsr_q;
        n_err   = '0;
        exp_bit = 1'b0;
        for (int i = 0; i < `NTI; i++) begin
            if (mode_i == CHK_ALIGN) begin
                lfsr_d = {lfsr_d[`NPRBS-2:0], rx_bits[i]};
            end else begin
                // x^7 + x^6 + 1
                exp_bit = lfsr_d[`NPRBS-1] ^ lfsr_d[`NPRBS-2];
                if (exp_bit != rx_bits[i]) n_err = n_err + 1'b1;
                lfsr_d = {lfsr_d[`NPRBS-2:0], exp_bit};
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i || mode_i == CHK_CLEAR) begin
            lfsr_q  <= '0;
            total_o <= '0;
            err_o   <= '0;
        end else if (mode_i == CHK_ALIGN) begin
            lfsr_q <= lfsr_d;
        end else if (mode_i == CHK_RUN) begin
            lfsr_q  <= lfsr_d;
            total_o <= total_o + bit_cnt_t'(`NTI);
            err_o   <= err_o + bit_cnt_t'(n_err);
        end
    end

    // errors never outrun the checked bits
    a_err_bounded: assert property (@(posedge clk_adc) disable iff (rst_i)
        err_o <= total_o);

endmodule

`default_nettype wire

// File: rtl/capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module capture_ctrl import dcore_pkg::*; (
    input  wire logic          clk_adc,
    input  wire logic          rst_i,
    input  wire logic          arm_i,
    input  wire logic          start_i,
    output cap_state_e         state_o,
    output logic               wr_en_o,
    output logic [`CAP_AW-1:0] wr_addr_o
);
    localparam logic [`CAP_AW-1:0] LAST_ADDR = `CAP_AW'(`CAP_DEPTH - 1);

    cap_state_e         state_q;
    logic [`CAP_AW-1:0] addr_q;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state_q <= CAP_IDLE;
            addr_q  <= '0;
        end else begin
            case (state_q)
                CAP_IDLE, CAP_DONE: if (arm_i) state_q <= CAP_ARMED;
                CAP_ARMED: begin
                    addr_q <= '0;
                    if (start_i) state_q <= CAP_WRITE;
                end
                CAP_WRITE: begin
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == LAST_ADDR) state_q <= CAP_DONE;
                end
                default: state_q <= CAP_IDLE;
            endcase
        end
    end

    assign state_o   = state_q;
    assign wr_en_o   = (state_q == CAP_WRITE);
    assign wr_addr_o = addr_q;

    // a burst always fills the whole memory
    a_full_burst: assert property (@(posedge clk_adc) disable iff (rst_i)
        $fell(wr_en_o) |-> $past(wr_addr_o) == LAST_ADDR && state_o == CAP_DONE);

endmodule

`default_nettype wire

// File: rtl/snapshot_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module snapshot_mem import dcore_pkg::*; (
    input  wire logic               clk_adc,
    input  wire logic               wr_en_i,
    input  wire logic [`CAP_AW-1:0] wr_addr_i,
    input  wire adc_code_t          wr_data_i [`NTI-1:0],
    input  wire logic [`CAP_AW-1:0] rd_addr_i,
    output adc_code_t               rd_data_o [`NTI-1:0]
);
    // one entry holds every slice of a cycle
    adc_code_t mem [`CAP_DEPTH-1:0][`NTI-1:0];

    always_ff @(posedge clk_adc) begin
        if (wr_en_i) begin
            for (int i = 0; i < `NTI; i++) begin
                mem[wr_addr_i][i] <= wr_data_i[i];
            end
        end
    end

    // asynchronous read for zero-wait APB
    always_comb begin
        for (int i = 0; i < `NTI; i++) begin
            rd_data_o[i] = mem[rd_addr_i][i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/digital_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module digital_core import dcore_pkg::*; (
    input  wire logic        clk_adc,
    input  wire logic        rst_i,
    input  wire adc_mag_t    adc_data_i [`NTI-1:0],
    input  wire logic [`NTI-1:0] adc_sign_i,
    input  wire logic        dump_start_i,
    input  wire logic [7:0]  paddr_i,
    input  wire logic        psel_i,
    input  wire logic        penable_i,
    input  wire logic        pwrite_i,
    input  wire logic [31:0] pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output adc_code_t        data_o [`NTI-1:0]
);
    dcore_cfg_if cfg ();

    logic               win_end;
    logic               cap_wr_en;
    logic [`CAP_AW-1:0] cap_wr_addr;

    dcore_regs regs_i (
        .clk_adc(clk_adc), .rst_i(rst_i),
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .cfg(cfg.regs)
    );

    // strobe shared by all slices
    avg_timer avg_timer_i (
        .clk_adc(clk_adc), .rst_i(rst_i), .navg_i(cfg.navg), .win_end_o(win_end)
    );

    genvar k;
    generate
        for (k = 0; k < `NTI; k++) begin : g_slice
            adc_unfold unfold_i (
                .clk_adc(clk_adc), .rst_i(rst_i),
                .mag_i(adc_data_i[k]), .sign_i(adc_sign_i[k]),
                .win_end_i(win_end), .cal_en_i(cfg.cal_en),
                .ext_ofs_en_i(cfg.ext_ofs_en), .ext_ofs_i(cfg.ext_ofs[k]),
                .navg_i(cfg.navg),
                .code_o(data_o[k]), .cal_ofs_o(cfg.cal_ofs[k])
            );
        end
    endgenerate

    prbs_checker prbs_i (
        .clk_adc(clk_adc), .rst_i(rst_i), .code_i(data_o), .mode_i(cfg.chk_mode),
        .total_o(cfg.prbs_total), .err_o(cfg.prbs_err)
    );

    capture_ctrl cap_ctrl_i (
        .clk_adc(clk_adc), .rst_i(rst_i), .arm_i(cfg.cap_arm), .start_i(dump_start_i),
        .state_o(cfg.cap_state), .wr_en_o(cap_wr_en), .wr_addr_o(cap_wr_addr)
    );

    snapshot_mem snap_i (
        .clk_adc(clk_adc), .wr_en_i(cap_wr_en), .wr_addr_i(cap_wr_addr),
        .wr_data_i(data_o), .rd_addr_i(cfg.cap_addr), .rd_data_o(cfg.cap_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_digital_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcore_config.svh"

module tb_digital_core import dcore_pkg::*; ();

    // test lengths add up to roughly 1500 cycles
    localparam int MAX_CYCLES = 6000;
    localparam int N_FLIP     = 3;
    localparam int CODE_MAX   = 2 ** (`NADC - 1) - 1;
    localparam int CODE_MIN   = -(2 ** (`NADC - 1));

    logic        clk_adc;
    logic        rst;
    adc_mag_t    adc_data [`NTI-1:0];
    logic [`NTI-1:0] adc_sign;
    logic        dump_start;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    adc_code_t   data_out [`NTI-1:0];

    int errors = 0;
    int cycles = 0;
    int seed   = 90266;

    digital_core uut (
        .clk_adc(clk_adc), .rst_i(rst), .adc_data_i(adc_data), .adc_sign_i(adc_sign),
        .dump_start_i(dump_start), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .data_o(data_out)
    );

    always #10 clk_adc = ~clk_adc;

    always @(posedge clk_adc) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_code(input string name, input adc_code_t exp, input adc_code_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_cnt(input string name, input bit_cnt_t exp, input bit_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input cap_state_e exp, input cap_state_e act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // setup and access phase followed by one idle cycle
    // response sampled mid access phase
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
        @(posedge clk_adc);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_adc);
        penable <= 1'b1;
        @(negedge clk_adc);
        err = pslverr;
        check_word("pready_o", 32'd1, 32'(pready));
        @(posedge clk_adc);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
        @(posedge clk_adc);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_adc);
        penable <= 1'b1;
        @(negedge clk_adc);
        rdata = prdata;
        err   = pslverr;
        check_word("pready_o", 32'd1, 32'(pready));
        @(posedge clk_adc);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [31:0] ctrl_word(input logic cal, input logic ext,
                                              input logic [2:0] navg, input chk_mode_e mode);
        return {25'd0, mode, navg, ext, cal};
    endfunction

    // signed code to magnitude and sign
    // zero goes out as a positive sample
    task automatic set_slice(input int k, input int code);
        adc_data[k] <= adc_mag_t'(code < 0 ? -code : code);
        adc_sign[k] <= (code >= 0);
    endtask

    function automatic adc_code_t expect_code(input adc_mag_t mag, input logic sign,
                                              input adc_code_t ofs);
        int raw;
        int diff;
        raw  = sign ? int'(mag) : -int'(mag);
        diff = raw - int'(ofs);
        if (diff > CODE_MAX) diff = CODE_MAX;
        if (diff < CODE_MIN) diff = CODE_MIN;
        return adc_code_t'(diff);
    endfunction

    task automatic test_regs();
        logic [31:0] wr;
        logic [31:0] rd;
        logic        err;
        wr = $random(seed) & 32'h7F;
        apb_write(REG_CTRL, wr, err);
        check_word("pslverr_o", 32'd0, 32'(err));
        apb_read(REG_CTRL, rd, err);
        check_word("REG_CTRL", wr, rd);
        wr = $random(seed);
        apb_write(REG_EXT_OFS, wr, err);
        apb_read(REG_EXT_OFS, rd, err);
        check_word("REG_EXT_OFS", wr, rd);
        wr = $random(seed) & (`CAP_DEPTH - 1);
        apb_write(REG_CAP_ADDR, wr, err);
        apb_read(REG_CAP_ADDR, rd, err);
        check_word("REG_CAP_ADDR", wr, rd);
        apb_read(8'h24, rd, err);
        check_word("pslverr_o", 32'd1, 32'(err));
        apb_write(REG_PRBS_TOT, 32'hFFFF_FFFF, err);
        check_word("pslverr_o", 32'd1, 32'(err));
        apb_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 3'd0, CHK_CLEAR), err);
    endtask

    task automatic test_unfold();
        logic [31:0] ofs_word;
        adc_mag_t    mag [`NTI-1:0];
        logic        sgn [`NTI-1:0];
        logic        err;
        ofs_word = $random(seed);
        apb_write(REG_EXT_OFS, ofs_word, err);
        apb_write(REG_CTRL, ctrl_word(1'b0, 1'b1, 3'd0, CHK_CLEAR), err);
        for (int n = 0; n < 500; n++) begin
            @(posedge clk_adc);
            for (int k = 0; k < `NTI; k++) begin
                mag[k] = adc_mag_t'($random(seed));
                sgn[k] = $random(seed) & 1;
                adc_data[k] <= mag[k];
                adc_sign[k] <= sgn[k];
            end
            @(posedge clk_adc);
            @(negedge clk_adc);
            for (int k = 0; k < `NTI; k++) begin
                check_code($sformatf("data_o[%0d]", k),
                           expect_code(mag[k], sgn[k], adc_code_t'(ofs_word[k*8 +: 8])),
                           data_out[k]);
            end
        end
    endtask

    task automatic test_calibration();
        logic [31:0] exp_word;
        logic [31:0] rd;
        logic        err;
        exp_word = '0;
        @(posedge clk_adc);
        for (int k = 0; k < `NTI; k++) begin
            set_slice(k, 7 * k - 11);
            exp_word[k*8 +: 8] = 8'(7 * k - 11);
        end
        // navg 2 gives four-cycle windows
        apb_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 3'd2, CHK_CLEAR), err);
        repeat (20) @(posedge clk_adc);
        apb_read(REG_CAL_OFS, rd, err);
        check_word("REG_CAL_OFS", exp_word, rd);
        @(negedge clk_adc);
        for (int k = 0; k < `NTI; k++) begin
            check_code($sformatf("data_o[%0d]", k), adc_code_t'(0), data_out[k]);
        end
    endtask

    task automatic test_prbs();
        logic [6:0]  lfsr;
        logic [31:0] rd;
        logic        err;
        logic        b;
        lfsr = 7'h5A;
        apb_write(REG_EXT_OFS, 32'd0, err);
        fork
            begin
                for (int c = 0; c < 90; c++) begin
                    @(posedge clk_adc);
                    for (int k = 0; k < `NTI; k++) begin
                        // x^7 + x^6 + 1 with the oldest bit in slice 0
                        b    = lfsr[6] ^ lfsr[5];
                        lfsr = {lfsr[5:0], b};
                        if (k < N_FLIP && c == 30 + 10 * k) b = !b;
                        set_slice(k, b ? 20 : -20);
                    end
                end
            end
            begin
                apb_write(REG_CTRL, ctrl_word(1'b0, 1'b1, 3'd0, CHK_ALIGN), err);
                repeat (8) @(posedge clk_adc);
                apb_write(REG_CTRL, ctrl_word(1'b0, 1'b1, 3'd0, CHK_RUN), err);
                repeat (60) @(posedge clk_adc);
                apb_write(REG_CTRL, ctrl_word(1'b0, 1'b1, 3'd0, CHK_FREEZE), err);
            end
        join
        apb_read(REG_PRBS_ERR, rd, err);
        check_cnt("prbs_err", bit_cnt_t'(N_FLIP), bit_cnt_t'(rd));
        apb_read(REG_PRBS_TOT, rd, err);
        if (rd == 0 || rd % `NTI != 0) begin
            errors++;
            $display("At %0t the PRBS total count %0d is not a nonzero multiple of %0d",
                     $time, rd, `NTI);
        end
    endtask

    task automatic test_capture();
        logic [31:0] rd;
        logic        err;
        adc_code_t   cur;
        adc_code_t   prev [`NTI-1:0];
        fork
            begin
                // ramp stays below zero so nothing saturates
                for (int c = 0; c < 60; c++) begin
                    @(posedge clk_adc);
                    for (int k = 0; k < `NTI; k++) set_slice(k, -90 + 10 * k + c);
                end
            end
            begin
                apb_write(REG_CAP_CTRL, 32'd1, err);
                apb_read(REG_CAP_CTRL, rd, err);
                check_state("cap_state", CAP_ARMED, cap_state_e'(rd[1:0]));
                @(posedge clk_adc);
                dump_start <= 1'b1;
                @(posedge clk_adc);
                dump_start <= 1'b0;
                rd = '0;
                while (cap_state_e'(rd[1:0]) != CAP_DONE) apb_read(REG_CAP_CTRL, rd, err);
            end
        join
        for (int a = 0; a < `CAP_DEPTH; a++) begin
            apb_write(REG_CAP_ADDR, a, err);
            apb_read(REG_CAP_DATA, rd, err);
            for (int k = 0; k < `NTI; k++) begin
                cur = adc_code_t'(rd[k*8 +: 8]);
                if (a > 0) check_code($sformatf("cap_data[%0d][%0d]", a, k), prev[k] + 1, cur);
                prev[k] = cur;
            end
        end
    endtask

    initial begin
        clk_adc    = 1'b0;
        rst        = 1'b1;
        adc_sign   = '0;
        dump_start = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        for (int k = 0; k < `NTI; k++) adc_data[k] = '0;
        repeat (8) @(posedge clk_adc);
        rst <= 1'b0;
        test_regs();
        test_unfold();
        test_calibration();
        test_prbs();
        test_capture();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/dcore_pkg.sv
rtl/dcore_cfg_if.sv
rtl/dcore_regs.sv
rtl/avg_timer.sv
rtl/adc_unfold.sv
rtl/prbs_checker.sv
rtl/capture_ctrl.sv
rtl/snapshot_mem.sv
rtl/digital_core.sv
bench/tb_digital_core.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tb_digital_core

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_digital_core -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_digital_core); echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
